// ==== tanimoto_pkg.sv ====
package tanimoto_pkg;

    // Vector and count geometry
    localparam int VECTOR_WIDTH = 32;
    localparam int CNT_WIDTH    = 6;
    localparam int SUM_WIDTH    = 7;
    localparam int TABLE_DEPTH  = 2 * VECTOR_WIDTH + 1;
    localparam int ID_WIDTH     = 8;

    // Broadcast to hit write, in cycles
    localparam int LANE_LATENCY = 2;

    typedef logic [VECTOR_WIDTH-1:0] vec_t;
    typedef logic [CNT_WIDTH-1:0]    cnt_t;
    typedef logic [SUM_WIDTH-1:0]    sum_t;
    typedef logic [ID_WIDTH-1:0]     vec_id_t;

    typedef struct packed {
        vec_id_t ref_id;
        vec_id_t cmp_id;
    } pair_t;

    typedef enum logic {
        LOAD_REF,
        COMPARE
    } phase_e;

    // Number of set bits in one vector word
    function automatic cnt_t popcount(vec_t v);
        cnt_t n;
        n = '0;
        for (int i = 0; i < VECTOR_WIDTH; i++) begin
            n = n + cnt_t'(v[i]);
        end
        return n;
    endfunction

endpackage

// ==== hit_if.sv ====
`timescale 1ns/1ps

interface hit_if #(
    parameter int FIFO_DEPTH = 8
) ();
    import tanimoto_pkg::*;

    logic                              hit_valid;
    pair_t                             hit_pair;
    // Fill level of the lane FIFO, driven by the merge side
    logic [$clog2(FIFO_DEPTH+1)-1:0]   hit_count;

    modport lane  (output hit_valid, output hit_pair, input hit_count);
    modport merge (input hit_valid, input hit_pair, output hit_count);

endinterface

// ==== ref_store.sv ====
`timescale 1ns/1ps

module ref_store #(
    parameter int REF_COUNT = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_vec_valid,
    input  tanimoto_pkg::vec_t    i_vec_data,
    input  logic                  i_vec_last,
    output logic                  o_vec_ready,
    input  logic                  i_room,
    input  logic                  i_session_end,
    output logic                  o_drained,
    output logic                  o_cmp_valid,
    output tanimoto_pkg::vec_t    o_cmp_vec,
    output tanimoto_pkg::cnt_t    o_cmp_cnt,
    output tanimoto_pkg::vec_id_t o_cmp_id,
    output tanimoto_pkg::vec_t    o_ref_vec [REF_COUNT],
    output tanimoto_pkg::cnt_t    o_ref_cnt [REF_COUNT],
    output tanimoto_pkg::vec_id_t o_ref_id  [REF_COUNT]
);
    import tanimoto_pkg::*;

    localparam int FILL_W  = $clog2(REF_COUNT) + 1;
    localparam int DRAIN_W = $clog2(LANE_LATENCY + 3);

    phase_e             phase;
    vec_id_t            id_cnt;
    logic [FILL_W-1:0]  ref_fill;
    logic               draining;
    logic [DRAIN_W-1:0] drain_cnt;
    logic               accept;

    // Input is blocked from the last compare word until the session ends
    assign o_vec_ready = i_room && !draining;
    assign accept      = i_vec_valid && o_vec_ready;
    // Last word's hits are in the lane FIFOs by now
    assign o_drained   = draining && (drain_cnt == DRAIN_W'(LANE_LATENCY + 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            phase       <= LOAD_REF;
            id_cnt      <= '0;
            ref_fill    <= '0;
            draining    <= 1'b0;
            drain_cnt   <= '0;
            o_cmp_valid <= 1'b0;
        end else begin
            o_cmp_valid <= accept && (phase == COMPARE);
            if (i_session_end) begin
                phase    <= LOAD_REF;
                id_cnt   <= '0;
                ref_fill <= '0;
                draining <= 1'b0;
            end else if (accept) begin
                id_cnt <= id_cnt + 1'b1;
                if (phase == LOAD_REF) begin
                    ref_fill <= ref_fill + 1'b1;
                    if (ref_fill == FILL_W'(REF_COUNT - 1)) begin
                        phase <= COMPARE;
                    end
                end else if (i_vec_last) begin
                    draining  <= 1'b1;
                    drain_cnt <= '0;
                end
            end else if (draining && (drain_cnt != DRAIN_W'(LANE_LATENCY + 2))) begin
                drain_cnt <= drain_cnt + 1'b1;
            end
        end
    end

    // References shift in at lane 0, compare words go out as a broadcast
    always_ff @(posedge clk) begin
        if (accept) begin
            if (phase == LOAD_REF) begin
                o_ref_vec[0] <= i_vec_data;
                o_ref_cnt[0] <= popcount(i_vec_data);
                o_ref_id[0]  <= id_cnt;
                for (int k = 1; k < REF_COUNT; k++) begin
                    o_ref_vec[k] <= o_ref_vec[k-1];
                    o_ref_cnt[k] <= o_ref_cnt[k-1];
                    o_ref_id[k]  <= o_ref_id[k-1];
                end
            end else begin
                o_cmp_vec <= i_vec_data;
                o_cmp_cnt <= popcount(i_vec_data);
                o_cmp_id  <= id_cnt;
            end
        end
    end

endmodule

// ==== threshold_table.sv ====
`timescale 1ns/1ps

module threshold_table #(
    parameter int REF_COUNT = 4
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               i_wb_cyc,
    input  logic               i_wb_stb,
    input  logic               i_wb_we,
    input  tanimoto_pkg::sum_t i_wb_adr,
    input  tanimoto_pkg::cnt_t i_wb_dat,
    output tanimoto_pkg::cnt_t o_wb_dat,
    output logic               o_wb_ack,
    input  tanimoto_pkg::sum_t i_sum [REF_COUNT],
    output tanimoto_pkg::cnt_t o_thr [REF_COUNT]
);
    import tanimoto_pkg::*;

    cnt_t mem [TABLE_DEPTH];
    logic req;
    logic in_range;

    // A new access is taken only while no ack is out
    assign req      = i_wb_cyc && i_wb_stb && !o_wb_ack;
    assign in_range = i_wb_adr < SUM_WIDTH'(TABLE_DEPTH);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_wb_ack <= 1'b0;
        end else begin
            o_wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req && i_wb_we && in_range) begin
            mem[i_wb_adr] <= i_wb_dat;
        end
        if (req) begin
            o_wb_dat <= in_range ? mem[i_wb_adr] : '0;
        end
    end

    // Lane lookups, a+b never exceeds 2*VECTOR_WIDTH
    for (genvar l = 0; l < REF_COUNT; l++) begin : g_rd
        assign o_thr[l] = mem[i_sum[l]];
    end

endmodule

// ==== compare_lane.sv ====
`timescale 1ns/1ps

module compare_lane (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  i_cmp_valid,
    input  tanimoto_pkg::vec_t    i_cmp_vec,
    input  tanimoto_pkg::cnt_t    i_cmp_cnt,
    input  tanimoto_pkg::vec_id_t i_cmp_id,
    input  tanimoto_pkg::vec_t    i_ref_vec,
    input  tanimoto_pkg::cnt_t    i_ref_cnt,
    input  tanimoto_pkg::vec_id_t i_ref_id,
    output tanimoto_pkg::sum_t    o_sum,
    input  tanimoto_pkg::cnt_t    i_thr,
    hit_if.lane                   hit
);
    import tanimoto_pkg::*;

    logic  s1_valid;
    cnt_t  s1_c;
    sum_t  s1_sum;
    pair_t s1_pair;
    logic  s2_valid;
    pair_t s2_pair;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_cmp_valid;
            // Match when c reaches the threshold for this a+b
            s2_valid <= s1_valid && (s1_c >= i_thr);
        end
    end

    always_ff @(posedge clk) begin
        if (i_cmp_valid) begin
            s1_c           <= popcount(i_ref_vec & i_cmp_vec);
            s1_sum         <= sum_t'(i_ref_cnt) + sum_t'(i_cmp_cnt);
            s1_pair.ref_id <= i_ref_id;
            s1_pair.cmp_id <= i_cmp_id;
        end
        s2_pair <= s1_pair;
    end

    // Table address for stage two
    assign o_sum = s1_sum;

    assign hit.hit_valid = s2_valid;
    assign hit.hit_pair  = s2_pair;

endmodule

// ==== pair_fifo.sv ====
`timescale 1ns/1ps

module pair_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            i_wr,
    input  tanimoto_pkg::pair_t             i_din,
    input  logic                            i_rd,
    output tanimoto_pkg::pair_t             o_dout,
    output logic                            o_empty,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] o_count
);
    import tanimoto_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    pair_t         mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic          do_wr;
    logic          do_rd;

    assign o_empty = (o_count == '0);
    assign do_wr   = i_wr && (o_count != CW'(FIFO_DEPTH));
    assign do_rd   = i_rd && !o_empty;
    // Head is visible without a read strobe
    assign o_dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            o_count <= o_count + CW'(do_wr) - CW'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_din;
        end
    end

endmodule

// ==== hit_merge.sv ====
`timescale 1ns/1ps

module hit_merge #(
    parameter int REF_COUNT  = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rstn,
    hit_if.merge                hits [REF_COUNT],
    input  logic                i_drained,
    output logic                o_session_end,
    output logic                o_room,
    output logic                o_pair_valid,
    output tanimoto_pkg::pair_t o_pair_data,
    output logic                o_pair_last,
    input  logic                i_pair_ready
);
    import tanimoto_pkg::*;

    localparam int CW = $clog2(FIFO_DEPTH + 1);
    localparam int SW = (REF_COUNT > 1) ? $clog2(REF_COUNT) : 1;

    pair_t                head       [REF_COUNT];
    logic [CW-1:0]        lane_count [REF_COUNT];
    logic [REF_COUNT-1:0] empty;
    logic [REF_COUNT-1:0] pop;
    logic [REF_COUNT-1:0] lane_room;
    logic [SW-1:0]        sel_comb;
    logic [SW-1:0]        sel_hold;
    logic [SW-1:0]        sel;
    logic                 hold;
    logic                 drained_seen;
    logic                 any_data;
    logic                 last_beat;
    logic                 take;

    for (genvar g = 0; g < REF_COUNT; g++) begin : g_lane
        pair_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rstn    (rstn),
            .i_wr    (hits[g].hit_valid),
            .i_din   (hits[g].hit_pair),
            .i_rd    (pop[g]),
            .o_dout  (head[g]),
            .o_empty (empty[g]),
            .o_count (hits[g].hit_count)
        );
        assign lane_count[g] = hits[g].hit_count;
        // Space for every hit that may still be in flight
        assign lane_room[g]  = (int'(lane_count[g]) + LANE_LATENCY + 2) <= FIFO_DEPTH;
        assign pop[g]        = take && !last_beat && (sel == SW'(g));
    end

    // Fullest non-empty lane wins, lowest lane on a tie
    always_comb begin
        logic [CW-1:0] best;
        logic          found;
        best     = '0;
        found    = 1'b0;
        sel_comb = '0;
        for (int i = 0; i < REF_COUNT; i++) begin
            if (!empty[i] && (!found || lane_count[i] > best)) begin
                sel_comb = SW'(i);
                best     = lane_count[i];
                found    = 1'b1;
            end
        end
    end

    // A stalled beat keeps its lane so the data stays stable
    assign sel           = hold ? sel_hold : sel_comb;
    assign any_data      = |(~empty);
    assign last_beat     = drained_seen && !any_data;
    assign o_pair_valid  = any_data || last_beat;
    assign o_pair_last   = last_beat;
    assign o_pair_data   = last_beat ? '0 : head[sel];
    assign take          = o_pair_valid && i_pair_ready;
    assign o_session_end = last_beat && i_pair_ready;
    assign o_room        = &lane_room;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            hold         <= 1'b0;
            sel_hold     <= '0;
            drained_seen <= 1'b0;
        end else begin
            hold     <= any_data && !i_pair_ready;
            sel_hold <= sel;
            if (o_session_end) begin
                drained_seen <= 1'b0;
            end else if (i_drained) begin
                drained_seen <= 1'b1;
            end
        end
    end

endmodule

// ==== tanimoto_top.sv ====
`timescale 1ns/1ps

module tanimoto_top #(
    parameter int REF_COUNT  = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_vec_valid,
    input  tanimoto_pkg::vec_t  i_vec_data,
    input  logic                i_vec_last,
    output logic                o_vec_ready,
    output logic                o_pair_valid,
    output tanimoto_pkg::pair_t o_pair_data,
    output logic                o_pair_last,
    input  logic                i_pair_ready,
    input  logic                i_wb_cyc,
    input  logic                i_wb_stb,
    input  logic                i_wb_we,
    input  tanimoto_pkg::sum_t  i_wb_adr,
    input  tanimoto_pkg::cnt_t  i_wb_dat,
    output tanimoto_pkg::cnt_t  o_wb_dat,
    output logic                o_wb_ack
);
    import tanimoto_pkg::*;

    logic    room;
    logic    session_end;
    logic    drained;
    logic    cmp_valid;
    vec_t    cmp_vec;
    cnt_t    cmp_cnt;
    vec_id_t cmp_id;
    vec_t    ref_vec  [REF_COUNT];
    cnt_t    ref_cnt  [REF_COUNT];
    vec_id_t ref_id   [REF_COUNT];
    sum_t    lane_sum [REF_COUNT];
    cnt_t    lane_thr [REF_COUNT];

    hit_if #(.FIFO_DEPTH(FIFO_DEPTH)) hit_bus [REF_COUNT] ();

    ref_store #(
        .REF_COUNT (REF_COUNT)
    ) u_ref_store (
        .clk           (clk),
        .rstn          (rstn),
        .i_vec_valid   (i_vec_valid),
        .i_vec_data    (i_vec_data),
        .i_vec_last    (i_vec_last),
        .o_vec_ready   (o_vec_ready),
        .i_room        (room),
        .i_session_end (session_end),
        .o_drained     (drained),
        .o_cmp_valid   (cmp_valid),
        .o_cmp_vec     (cmp_vec),
        .o_cmp_cnt     (cmp_cnt),
        .o_cmp_id      (cmp_id),
        .o_ref_vec     (ref_vec),
        .o_ref_cnt     (ref_cnt),
        .o_ref_id      (ref_id)
    );

    threshold_table #(
        .REF_COUNT (REF_COUNT)
    ) u_threshold_table (
        .clk      (clk),
        .rstn     (rstn),
        .i_wb_cyc (i_wb_cyc),
        .i_wb_stb (i_wb_stb),
        .i_wb_we  (i_wb_we),
        .i_wb_adr (i_wb_adr),
        .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat),
        .o_wb_ack (o_wb_ack),
        .i_sum    (lane_sum),
        .o_thr    (lane_thr)
    );

    // One scoring lane per stored reference
    for (genvar g = 0; g < REF_COUNT; g++) begin : g_lane
        compare_lane u_compare_lane (
            .clk         (clk),
            .rstn        (rstn),
            .i_cmp_valid (cmp_valid),
            .i_cmp_vec   (cmp_vec),
            .i_cmp_cnt   (cmp_cnt),
            .i_cmp_id    (cmp_id),
            .i_ref_vec   (ref_vec[g]),
            .i_ref_cnt   (ref_cnt[g]),
            .i_ref_id    (ref_id[g]),
            .o_sum       (lane_sum[g]),
            .i_thr       (lane_thr[g]),
            .hit         (hit_bus[g])
        );
    end

    hit_merge #(
        .REF_COUNT  (REF_COUNT),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_hit_merge (
        .clk           (clk),
        .rstn          (rstn),
        .hits          (hit_bus),
        .i_drained     (drained),
        .o_session_end (session_end),
        .o_room        (room),
        .o_pair_valid  (o_pair_valid),
        .o_pair_data   (o_pair_data),
        .o_pair_last   (o_pair_last),
        .i_pair_ready  (i_pair_ready)
    );

endmodule

// ==== tanimoto_sva.sv ====
`timescale 1ns/1ps

module tanimoto_sva (
    input logic        clk,
    input logic        rstn,
    input logic        o_pair_valid,
    input logic [15:0] o_pair_data,
    input logic        o_pair_last,
    input logic        i_pair_ready,
    input logic        o_wb_ack,
    input logic        o_vec_ready
);

    ack_single: assert property (@(posedge clk) disable iff (!rstn)
        o_wb_ack |=> !o_wb_ack)
        else $error("wishbone ack lasted two cycles");

    // A stalled beat keeps valid, data and last
    pair_stall: assert property (@(posedge clk) disable iff (!rstn)
        (o_pair_valid && !i_pair_ready) |=>
            (o_pair_valid && $stable(o_pair_data) && $stable(o_pair_last)))
        else $error("pair stream changed under a stall");

    reset_values: assert property (@(posedge clk)
        !rstn |=> (!o_pair_valid && !o_pair_last && !o_wb_ack && o_vec_ready))
        else $error("outputs not at reset values");

endmodule

// ==== tanimoto_checker.sv ====
`timescale 1ns/1ps

module tanimoto_checker #(
    parameter int REF_COUNT = 4
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        i_vec_valid,
    input  logic [31:0] i_vec_data,
    input  logic        i_vec_last,
    input  logic        o_vec_ready,
    input  logic        o_pair_valid,
    input  logic [15:0] o_pair_data,
    input  logic        o_pair_last,
    input  logic        i_pair_ready,
    input  logic        i_wb_cyc,
    input  logic        i_wb_stb,
    input  logic        i_wb_we,
    input  logic [6:0]  i_wb_adr,
    input  logic [5:0]  i_wb_dat,
    input  logic [5:0]  o_wb_dat,
    input  logic        o_wb_ack,
    output int          o_errors,
    output int          o_sessions,
    output int          o_pairs,
    output logic        o_stall_seen
);

    logic [31:0] refs [REF_COUNT];
    logic [5:0]  thr [128];
    bit          expected [REF_COUNT][256];
    bit          seen [REF_COUNT][256];
    int          last_cmp [REF_COUNT];
    int          nrefs;
    int          next_id;
    bit          draining;
    bit          req_prev;
    bit          req_we;
    logic [6:0]  req_adr;
    logic [5:0]  req_dat;
    bit          stall_prev;
    logic [15:0] data_prev;
    logic        last_prev;

    function automatic int ones_in(logic [31:0] v);
        int n;
        n = 0;
        for (int i = 0; i < 32; i++) begin
            n += int'(v[i]);
        end
        return n;
    endfunction

    task automatic mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
        o_errors++;
    endtask

    task automatic fail_note(string msg);
        $display("ERROR t=%0t %s", $time, msg);
        o_errors++;
    endtask

    task automatic new_session();
        for (int r = 0; r < REF_COUNT; r++) begin
            last_cmp[r] = -1;
            for (int k = 0; k < 256; k++) begin
                expected[r][k] = 0;
                seen[r][k]     = 0;
            end
        end
        nrefs    = 0;
        next_id  = 0;
        draining = 0;
    endtask

    initial begin
        o_errors     = 0;
        o_sessions   = 0;
        o_pairs      = 0;
        o_stall_seen = 0;
        req_prev     = 0;
        stall_prev   = 0;
        for (int k = 0; k < 128; k++) begin
            thr[k] = '0;
        end
        new_session();
    end

    always @(posedge clk) begin
        int a;
        int b;
        int c;
        int r;
        int k;
        logic [5:0] exp_dat;
        if (!rstn) begin
            new_session();
            req_prev   = 0;
            stall_prev = 0;
        end else begin
            // Wishbone ack one cycle after the strobe, reads against seen writes
            if (o_wb_ack) begin
                if (!req_prev) fail_note("wishbone ack without a request the cycle before");
                if (req_we) begin
                    if (req_adr < 7'd65) thr[req_adr] = req_dat;
                end else begin
                    exp_dat = (req_adr < 7'd65) ? thr[req_adr] : 6'd0;
                    if (o_wb_dat !== exp_dat)
                        mismatch("o_wb_dat", 32'(o_wb_dat), 32'(exp_dat));
                end
            end else if (req_prev) begin
                fail_note("wishbone ack missing one cycle after the strobe");
            end
            req_prev = i_wb_cyc && i_wb_stb && !o_wb_ack;
            // Request fields are kept, the master drops them once ack is out
            if (req_prev) begin
                req_we  = i_wb_we;
                req_adr = i_wb_adr;
                req_dat = i_wb_dat;
            end

            if (i_vec_valid && !o_vec_ready && !draining && nrefs == REF_COUNT)
                o_stall_seen = 1;

            if (i_vec_valid && o_vec_ready) begin
                if (draining) fail_note("vector accepted while the session drains");
                if (nrefs < REF_COUNT) begin
                    refs[nrefs] = i_vec_data;
                    nrefs++;
                end else begin
                    b = ones_in(i_vec_data);
                    for (r = 0; r < REF_COUNT; r++) begin
                        a = ones_in(refs[r]);
                        c = ones_in(refs[r] & i_vec_data);
                        if (c >= int'(thr[a + b])) expected[r][next_id] = 1;
                    end
                    if (i_vec_last) draining = 1;
                end
                next_id++;
            end

            // A stalled beat must be offered again unchanged
            if (stall_prev) begin
                if (!o_pair_valid) fail_note("o_pair_valid dropped before the beat was taken");
                if (o_pair_data !== data_prev) mismatch("o_pair_data", 32'(o_pair_data),
                                                        32'(data_prev));
                if (o_pair_last !== last_prev) mismatch("o_pair_last", 32'(o_pair_last),
                                                        32'(last_prev));
            end
            stall_prev = o_pair_valid && !i_pair_ready;
            data_prev  = o_pair_data;
            last_prev  = o_pair_last;

            if (o_pair_valid && i_pair_ready) begin
                r = int'(o_pair_data[15:8]);
                k = int'(o_pair_data[7:0]);
                if (o_pair_last) begin
                    if (o_pair_data !== 16'h0) mismatch("o_pair_data", 32'(o_pair_data), 0);
                    if (!draining) fail_note("last beat without a finished session");
                    for (int x = 0; x < REF_COUNT; x++) begin
                        for (int y = 0; y < 256; y++) begin
                            if (expected[x][y] && !seen[x][y]) begin
                                $display("ERROR t=%0t pair ref %0d cmp %0d never emitted",
                                         $time, x, y);
                                o_errors++;
                            end
                        end
                    end
                    o_sessions++;
                    new_session();
                end else if (r >= REF_COUNT || !expected[r][k]) begin
                    fail_note($sformatf("unexpected pair %h", o_pair_data));
                end else if (seen[r][k]) begin
                    fail_note($sformatf("duplicate pair %h", o_pair_data));
                end else begin
                    seen[r][k] = 1;
                    o_pairs++;
                    if (k <= last_cmp[r]) fail_note($sformatf("pair %h out of order", o_pair_data));
                    last_cmp[r] = k;
                end
            end
        end
    end

endmodule

// ==== tb_tanimoto.sv ====
`timescale 1ns/1ps

module tb_tanimoto;

    localparam int NROWS  = 28;
    localparam int WB_OPS = 71;
    localparam int LIMIT  = 40 * NROWS + 300 + 4 * WB_OPS;

    logic        clk;
    logic        rstn;
    logic        i_vec_valid;
    logic [31:0] i_vec_data;
    logic        i_vec_last;
    logic        o_vec_ready;
    logic        o_pair_valid;
    logic [15:0] o_pair_data;
    logic        o_pair_last;
    logic        i_pair_ready;
    logic        i_wb_cyc;
    logic        i_wb_stb;
    logic        i_wb_we;
    logic [6:0]  i_wb_adr;
    logic [5:0]  i_wb_dat;
    logic [5:0]  o_wb_dat;
    logic        o_wb_ack;
    int          errors;
    int          sessions;
    int          pairs;
    logic        stall_seen;
    int          tb_errors;
    int          cycles;
    int          seed;

    // Columns: vector word, last flag, i_pair_ready pattern over 8 cycles
    logic [31:0] row_vec   [NROWS];
    logic        row_last  [NROWS];
    logic [7:0]  row_ready [NROWS];

    tanimoto_top u_tanimoto_top (.*);

    tanimoto_checker u_checker (
        .clk (clk), .rstn (rstn),
        .i_vec_valid (i_vec_valid), .i_vec_data (i_vec_data), .i_vec_last (i_vec_last),
        .o_vec_ready (o_vec_ready), .o_pair_valid (o_pair_valid),
        .o_pair_data (o_pair_data), .o_pair_last (o_pair_last),
        .i_pair_ready (i_pair_ready), .i_wb_cyc (i_wb_cyc), .i_wb_stb (i_wb_stb),
        .i_wb_we (i_wb_we), .i_wb_adr (i_wb_adr), .i_wb_dat (i_wb_dat),
        .o_wb_dat (o_wb_dat), .o_wb_ack (o_wb_ack), .o_errors (errors),
        .o_sessions (sessions), .o_pairs (pairs), .o_stall_seen (stall_seen)
    );

    bind tanimoto_top tanimoto_sva u_sva (
        .clk (clk), .rstn (rstn), .o_pair_valid (o_pair_valid),
        .o_pair_data (o_pair_data), .o_pair_last (o_pair_last),
        .i_pair_ready (i_pair_ready), .o_wb_ack (o_wb_ack), .o_vec_ready (o_vec_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    task automatic set_row(int idx, logic [31:0] vec, logic last, logic [7:0] pat);
        row_vec[idx]   = vec;
        row_last[idx]  = last;
        row_ready[idx] = pat;
    endtask

    // One single-cycle Wishbone classic access, inputs move on the falling edge
    task automatic wb_access(logic we, logic [6:0] adr, logic [5:0] dat);
        i_wb_cyc = 1'b1;
        i_wb_stb = 1'b1;
        i_wb_we  = we;
        i_wb_adr = adr;
        i_wb_dat = dat;
        do begin
            @(negedge clk);
        end while (!o_wb_ack);
        i_wb_cyc = 1'b0;
        i_wb_stb = 1'b0;
        i_wb_we  = 1'b0;
    endtask

    initial begin
        int step;
        logic accepted;
        seed         = 32'he5d2;
        cycles       = 0;
        tb_errors    = 0;
        step         = 0;
        rstn         = 1'b0;
        i_vec_valid  = 1'b0;
        i_vec_data   = '0;
        i_vec_last   = 1'b0;
        i_pair_ready = 1'b1;
        i_wb_cyc     = 1'b0;
        i_wb_stb     = 1'b0;
        i_wb_we      = 1'b0;
        i_wb_adr     = '0;
        i_wb_dat     = '0;

        // Session one, references 0 to 2 match an all-ones word
        set_row(0, 32'h0000ffff, 1'b0, 8'hff);
        set_row(1, 32'hffff0000, 1'b0, 8'hff);
        set_row(2, 32'h0f0f0f0f, 1'b0, 8'hff);
        set_row(3, $random(seed), 1'b0, 8'hff);
        set_row(4, 32'h0000ffff, 1'b0, 8'hff);
        set_row(5, 32'h0f0f0f0f, 1'b0, 8'hff);
        for (int i = 6; i < 13; i++) begin
            set_row(i, 32'hffffffff, 1'b0, 8'h01);
        end
        set_row(13, 32'hffff0000, 1'b1, 8'hff);
        // Session two, mostly random words
        for (int i = 14; i < 28; i++) begin
            set_row(i, $random(seed), 1'b0, (i % 3 == 0) ? 8'h55 : 8'hff);
        end
        set_row(18, row_vec[14], 1'b0, 8'hff);
        set_row(19, 32'hffffffff, 1'b0, 8'hff);
        set_row(27, row_vec[17], 1'b1, 8'hff);

        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        for (int s = 0; s < 65; s++) begin
            wb_access(1'b1, 7'(s), 6'((s + 2) / 3));
        end
        wb_access(1'b0, 7'd0, '0);
        wb_access(1'b0, 7'd7, '0);
        wb_access(1'b0, 7'd33, '0);
        wb_access(1'b0, 7'd64, '0);
        wb_access(1'b0, 7'd65, '0);
        wb_access(1'b0, 7'd127, '0);

        for (int i = 0; i < NROWS; i++) begin
            i_vec_valid = 1'b1;
            i_vec_data  = row_vec[i];
            i_vec_last  = row_last[i];
            do begin
                i_pair_ready = row_ready[i][step % 8];
                step++;
                // Ready only moves on a rising edge, so the next edge sees this value
                accepted = o_vec_ready;
                @(negedge clk);
            end while (!accepted);
        end
        i_vec_valid  = 1'b0;
        i_vec_last   = 1'b0;
        i_pair_ready = 1'b1;
        while (sessions < 2) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);

        if (!stall_seen) begin
            $display("ERROR o_vec_ready never dropped under back-pressure");
            tb_errors++;
        end
        if (pairs == 0) begin
            $display("ERROR no match pairs were emitted");
            tb_errors++;
        end
        $display("Run complete: checker errors %0d, testbench errors %0d, pairs %0d, sessions %0d",
                 errors, tb_errors, pairs, sessions);
        if (errors == 0 && tb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== tanimoto_top.f ====
tanimoto_pkg.sv
hit_if.sv
ref_store.sv
threshold_table.sv
compare_lane.sv
pair_fifo.sv
hit_merge.sv
tanimoto_top.sv
tanimoto_sva.sv
tanimoto_checker.sv
tb_tanimoto.sv

// ==== Makefile ====
SRCS := $(shell cat tanimoto_top.f)

obj_dir/Vtb_tanimoto: $(SRCS) tanimoto_top.f
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tanimoto -f tanimoto_top.f

.PHONY: run clean

run: obj_dir/Vtb_tanimoto
	@out="$$(./obj_dir/Vtb_tanimoto)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
